// File: design/vic_pkg.sv
// shared geometry, register offsets, phase states and palette; imported by every vic module
package vic_pkg;

   // clock and beam geometry, one fixed ntsc-like standard
   localparam int dot_ticks       = 4;     // clk_dot4x cycles per dot
   localparam int dots_per_cycle  = 8;     // dots per cpu cycle
   localparam int cycles_per_line = 65;
   localparam int dots_per_line   = cycles_per_line * dots_per_cycle;  // 520
   localparam int lines_per_frame = 263;
   localparam int phi_half_ticks  = dot_ticks * dots_per_cycle / 2;    // 16

   localparam int hsync_dots   = 40;       // hsync high at line start
   localparam int vsync_lines  = 3;        // vsync high at frame start
   localparam int hblank_dots  = 80;       // inactive before this dot
   localparam int vblank_lines = 16;       // inactive before this line

   // display window, bounds inclusive
   localparam int win_x0 = 136;
   localparam int win_x1 = 455;
   localparam int win_y0 = 51;
   localparam int win_y1 = 250;

   localparam int raster_w = 9;            // raster line counter
   localparam int xpos_w   = 10;           // dot counter

   // register offsets on the 6 bit cpu address
   typedef enum logic [5:0] {
      reg_ctrl1    = 6'h11,                // bit 7 is compare bit 8
      reg_raster   = 6'h12,                // compare low byte
      reg_irq_stat = 6'h19,                // write 1 to clear
      reg_irq_en   = 6'h1a,
      reg_border   = 6'h20,
      reg_bg       = 6'h21
   } vic_reg_e;

   typedef enum logic {
      ph_low,
      ph_high
   } phase_e;

   // 16 colors as {r,g,b}, 6 bits each
   localparam logic [17:0] palette [0:15] = '{
      {6'h00, 6'h00, 6'h00},               // black
      {6'h3f, 6'h3f, 6'h3f},               // white
      {6'h1a, 6'h09, 6'h0b},               // red
      {6'h1c, 6'h35, 6'h33},               // cyan
      {6'h1b, 6'h0b, 6'h2a},               // purple
      {6'h15, 6'h2c, 6'h0e},               // green
      {6'h0a, 6'h07, 6'h27},               // blue
      {6'h2f, 6'h32, 6'h15},               // yellow
      {6'h1b, 6'h10, 6'h05},               // orange
      {6'h10, 6'h0b, 6'h00},               // brown
      {6'h2c, 6'h19, 6'h1b},               // light red
      {6'h11, 6'h11, 6'h11},               // dark grey
      {6'h1c, 6'h1c, 6'h1c},               // mid grey
      {6'h2a, 6'h3f, 6'h25},               // light green
      {6'h1c, 6'h1a, 6'h3b},               // light blue
      {6'h29, 6'h29, 6'h29}                // light grey
   };

endpackage

// File: design/vic_beam_if.sv
// beam position and dot/phase strobes, driven by the timing controller, read by regs and pixel path
`timescale 1ns/1ps

interface vic_beam_if import vic_pkg::*; ();

   logic [xpos_w-1:0]   xpos;             // dot within line
   logic [raster_w-1:0] ypos;             // raster line
   logic                dot_stb;          // last tick of each dot
   logic                phi_end;          // last tick of phi high
   logic                line_start;       // first tick of dot 0

   // timing controller owns every signal
   modport controller (
      output xpos,
      output ypos,
      output dot_stb,
      output phi_end,
      output line_start
   );

   // register bank needs raster line and the bus/line strobes
   modport regs (
      input ypos,
      input dot_stb,
      input phi_end,
      input line_start
   );

   // pixel path only looks at position
   modport pixel (
      input xpos,
      input ypos
   );

endinterface

// File: design/vic_timing_ctrl.sv
// timing controller; divides clk_dot4x into dots and phi, and runs the raster counters
`timescale 1ns/1ps

module vic_timing_ctrl import vic_pkg::*; (
   input  logic         clk_dot4x,
   input  logic         arst_n,
   vic_beam_if.controller beam,
   output logic         phi                 // cpu phase clock
);

   localparam int tick_w = $clog2(dot_ticks);
   localparam int ph_w   = $clog2(phi_half_ticks);

   logic [tick_w-1:0]   tick_cnt;           // tick within dot
   logic [ph_w-1:0]     ph_cnt;             // tick within phi half
   phase_e              ph_state;
   logic [xpos_w-1:0]   x_q;
   logic [raster_w-1:0] y_q;
   logic                ph_last;            // last tick of either half

   // dot tick counter
   always_ff @(posedge clk_dot4x or negedge arst_n) begin
      if (!arst_n) begin
         tick_cnt <= '0;
      end else begin
         tick_cnt <= tick_cnt + 1'b1;       // wraps at dot_ticks, power of two
      end
   end

   assign beam.dot_stb = (tick_cnt == tick_w'(dot_ticks - 1));

   // phase fsm, low half first after reset
   assign ph_last = (ph_cnt == ph_w'(phi_half_ticks - 1));

   always_ff @(posedge clk_dot4x or negedge arst_n) begin
      if (!arst_n) begin
         ph_state <= ph_low;
         ph_cnt   <= '0;
      end else begin
         ph_cnt <= ph_last ? '0 : ph_cnt + 1'b1;
         if (ph_last) begin
            case (ph_state)
               ph_low:  ph_state <= ph_high;
               ph_high: ph_state <= ph_low;
               default: ph_state <= ph_low;
            endcase
         end
      end
   end

   assign phi          = (ph_state == ph_high);
   assign beam.phi_end = (ph_state == ph_high) && ph_last;

   // raster counters, dot advances on dot_stb
   always_ff @(posedge clk_dot4x or negedge arst_n) begin
      if (!arst_n) begin
         x_q <= '0;
         y_q <= '0;
      end else if (beam.dot_stb) begin
         if (x_q == xpos_w'(dots_per_line - 1)) begin
            x_q <= '0;                      // line wrap
            if (y_q == raster_w'(lines_per_frame - 1)) begin
               y_q <= '0;                   // frame wrap
            end else begin
               y_q <= y_q + 1'b1;
            end
         end else begin
            x_q <= x_q + 1'b1;
         end
      end
   end

   assign beam.xpos = x_q;
   assign beam.ypos = y_q;

   // high for the whole first tick of dot 0
   assign beam.line_start = (x_q == '0) && (tick_cnt == '0);

endmodule

// File: design/vic_regs.sv
// cpu register bank; bus decode, readback, raster compare and irq, driven from vic_top pins
`timescale 1ns/1ps

module vic_regs import vic_pkg::*; (
   input  logic       clk_dot4x,
   input  logic       arst_n,
   vic_beam_if.regs   beam,
   input  logic       ce,                   // chip enable, low active
   input  logic       rw,                   // high read, low write
   input  logic [5:0] adi,
   input  logic [7:0] dbi,
   output logic [7:0] dbo,
   output logic       ls245_data_dir,
   output logic       irq,                  // low active
   output logic [3:0] border_col,
   output logic [3:0] bg_col
);

   logic [7:0]          ctrl1_q;            // bit 7 is compare bit 8
   logic [7:0]          raster_cmp_q;       // compare low byte
   logic [7:0]          irq_en_q;           // bit 0 enables raster irq
   logic                raster_flag;        // sticky match flag
   logic                irq_pend;
   logic [2:0]          dot_in_cyc;         // dot within cpu cycle
   logic                phi_hi;
   logic [raster_w-1:0] cmp_line;
   logic                raster_hit;
   logic                wr_stb;
   logic [7:0]          rd_data;

   // rebuild phi from the strobes, dots 4..7 of a cycle are phi high
   always_ff @(posedge clk_dot4x or negedge arst_n) begin
      if (!arst_n) begin
         dot_in_cyc <= '0;
      end else if (beam.phi_end) begin
         dot_in_cyc <= '0;                  // resync on cycle end
      end else if (beam.dot_stb) begin
         dot_in_cyc <= dot_in_cyc + 1'b1;
      end
   end

   assign phi_hi = dot_in_cyc[2];

   // writes land at the end of phi high
   assign wr_stb = beam.phi_end && !ce && !rw;

   assign cmp_line   = {ctrl1_q[7], raster_cmp_q};
   assign raster_hit = beam.line_start && (beam.ypos == cmp_line);

   always_ff @(posedge clk_dot4x or negedge arst_n) begin
      if (!arst_n) begin
         ctrl1_q      <= '0;
         raster_cmp_q <= '0;
         irq_en_q     <= '0;
         border_col   <= '0;
         bg_col       <= '0;
      end else if (wr_stb) begin
         case (vic_reg_e'(adi))
            reg_ctrl1:  ctrl1_q      <= dbi;
            reg_raster: raster_cmp_q <= dbi;
            reg_irq_en: irq_en_q     <= dbi;
            reg_border: border_col   <= dbi[3:0];
            reg_bg:     bg_col       <= dbi[3:0];
            default:    ;               // irq_stat handled with the flag
         endcase
      end
   end

   // sticky flag, a match in the same tick beats the clear
   always_ff @(posedge clk_dot4x or negedge arst_n) begin
      if (!arst_n) begin
         raster_flag <= 1'b0;
      end else if (raster_hit) begin
         raster_flag <= 1'b1;
      end else if (wr_stb && (vic_reg_e'(adi) == reg_irq_stat) && dbi[0]) begin
         raster_flag <= 1'b0;
      end
   end

   assign irq_pend = raster_flag && irq_en_q[0];
   assign irq      = ~irq_pend;             // falls with the flag

   // readback mux
   always_comb begin
      case (vic_reg_e'(adi))
         reg_ctrl1:    rd_data = {beam.ypos[8], ctrl1_q[6:0]};
         reg_raster:   rd_data = beam.ypos[7:0];   // live raster line
         reg_irq_stat: rd_data = {irq_pend, 6'b0, raster_flag};
         reg_irq_en:   rd_data = irq_en_q;
         reg_border:   rd_data = {4'hf, border_col};   // unused bits read 1
         reg_bg:       rd_data = {4'hf, bg_col};
         default:      rd_data = 8'hff;
      endcase
   end

   // read data follows the address by one tick
   always_ff @(posedge clk_dot4x or negedge arst_n) begin
      if (!arst_n) begin
         dbo <= '0;
      end else if (!ce && rw) begin
         dbo <= rd_data;
      end
   end

   assign ls245_data_dir = phi_hi && !ce && rw;   // chip drives the data bus

endmodule

// File: design/vic_pixel.sv
// pixel path; turns beam position and colors into registered syncs and palette rgb
`timescale 1ns/1ps

module vic_pixel import vic_pkg::*; (
   input  logic       clk_dot4x,
   input  logic       arst_n,
   vic_beam_if.pixel  beam,
   input  logic [3:0] border_col,
   input  logic [3:0] bg_col,
   output logic       hsync,
   output logic       vsync,
   output logic       active,
   output logic [5:0] red,
   output logic [5:0] green,
   output logic [5:0] blue
);

   logic        hs_d;
   logic        vs_d;
   logic        act_d;
   logic        in_win;                     // inside display window
   logic [3:0]  col_idx;
   logic [17:0] rgb_d;

   // position classification
   assign hs_d  = (beam.xpos < xpos_w'(hsync_dots));
   assign vs_d  = (beam.ypos < raster_w'(vsync_lines));
   assign act_d = (beam.xpos >= xpos_w'(hblank_dots)) &&
                  (beam.ypos >= raster_w'(vblank_lines));

   assign in_win = (beam.xpos >= xpos_w'(win_x0)) && (beam.xpos <= xpos_w'(win_x1)) &&
                   (beam.ypos >= raster_w'(win_y0)) && (beam.ypos <= raster_w'(win_y1));

   assign col_idx = in_win ? bg_col : border_col;   // background inside, border around
   assign rgb_d   = act_d ? palette[col_idx] : '0;  // black when blanked

   // outputs lag the beam by one tick
   always_ff @(posedge clk_dot4x or negedge arst_n) begin
      if (!arst_n) begin
         hsync  <= 1'b0;
         vsync  <= 1'b0;
         active <= 1'b0;
         red    <= '0;
         green  <= '0;
         blue   <= '0;
      end else begin
         hsync  <= hs_d;
         vsync  <= vs_d;
         active <= act_d;
         {red, green, blue} <= rgb_d;
      end
   end

endmodule

// File: design/vic_top.sv
// top level of the video chip core; wires timing, registers and pixel path to the pins
`timescale 1ns/1ps

module vic_top (
   input  logic       clk_dot4x,
   input  logic       arst_n,
   input  logic       ce,                   // low selects the chip
   input  logic       rw,                   // high read, low write
   input  logic [5:0] adl,                  // low address lines
   input  logic [7:0] dbl,                  // data bus in
   output logic [7:0] dbo,                  // data bus out
   output logic       phi,
   output logic       irq,
   output logic       ls245_data_dir,
   output logic       hsync,
   output logic       vsync,
   output logic       active,
   output logic [5:0] red,
   output logic [5:0] green,
   output logic [5:0] blue
);

   logic [3:0] border_col;
   logic [3:0] bg_col;

   vic_beam_if beam0 ();                    // position and strobes

   vic_timing_ctrl timing0 (
      .clk_dot4x (clk_dot4x),
      .arst_n    (arst_n),
      .beam      (beam0),
      .phi       (phi)
   );

   vic_regs regs0 (
      .clk_dot4x      (clk_dot4x),
      .arst_n         (arst_n),
      .beam           (beam0),
      .ce             (ce),
      .rw             (rw),
      .adi            (adl),
      .dbi            (dbl),
      .dbo            (dbo),
      .ls245_data_dir (ls245_data_dir),
      .irq            (irq),
      .border_col     (border_col),
      .bg_col         (bg_col)
   );

   vic_pixel pixel0 (
      .clk_dot4x  (clk_dot4x),
      .arst_n     (arst_n),
      .beam       (beam0),
      .border_col (border_col),
      .bg_col     (bg_col),
      .hsync      (hsync),
      .vsync      (vsync),
      .active     (active),
      .red        (red),
      .green      (green),
      .blue       (blue)
   );

endmodule

// File: verif/vic_properties.sv
// concurrent checks on phi strobes and irq that vic_tb binds into vic_timing_ctrl and vic_regs
`timescale 1ns/1ps

module vic_properties import vic_pkg::*; (
   input logic clk_dot4x,
   input logic arst_n,
   input logic phi,                         // phi or its rebuilt copy
   input logic phi_end,
   input logic dot_stb,
   input logic line_start,
   input logic irq                          // low active
);

   int fail_cnt = 0;                        // assertion failures so far

   // phi_end sits on the last tick of a dot in phi high
   phi_end_in_high: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
      phi_end |-> (phi && dot_stb)) else begin
      fail_cnt++;
      $error("phi_end outside the last tick of phi high");
   end

   // each phi half lasts 16 ticks
   phi_half_time: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
      $changed(phi) |-> ##phi_half_ticks $changed(phi)) else begin
      fail_cnt++;
      $error("phi half is not 16 ticks long");
   end

   // phi only rises on a dot boundary
   phi_rise_on_dot: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
      $rose(phi) |-> $past(dot_stb)) else begin
      fail_cnt++;
      $error("phi rose away from a dot boundary");
   end

   // irq release needs a cpu write, which only lands on phi_end
   irq_rise_after_write: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
      $rose(irq) |-> $past(phi_end)) else begin
      fail_cnt++;
      $error("irq rose without a register write");
   end

   // irq falls on a raster match at line start or on an enable write
   irq_fall_on_event: assert property (@(posedge clk_dot4x) disable iff (!arst_n)
      $fell(irq) |-> $past(line_start || phi_end)) else begin
      fail_cnt++;
      $error("irq fell away from a line start or a register write");
   end

endmodule

// File: verif/vic_tb.sv
// testbench for vic_top; runs the register table, beam timing, colors and raster irq checks
`timescale 1ns/1ps

module vic_tb import vic_pkg::*; ();

   typedef enum int {s_phi, s_hsync, s_vsync, s_irq} probe_e;

   logic       clk_dot4x;
   logic       arst_n;
   logic       ce;
   logic       rw;
   logic [5:0] adl;
   logic [7:0] dbl;
   wire  [7:0] dbo;
   wire        phi, irq, ls245_data_dir, hsync, vsync, active;
   wire  [5:0] red, green, blue;

   int         cyc;                         // rising edges seen so far
   int         vs_cyc;                      // cyc at the vsync rise that marks line 0 dot 0
   int         err_cnt;
   int         seed_val;
   int         line_t  = dots_per_line * dot_ticks;      // 2080 ticks
   int         frame_t = dots_per_line * dot_ticks * lines_per_frame;
   logic [3:0] border_c;
   logic [3:0] bg_c;

   // register table of name, offset, write enable, write data, expected readback and live bits
   string      tname [0:7];
   logic [5:0] toff  [0:7];
   logic       twr   [0:7];
   logic [7:0] tdat  [0:7];
   logic [7:0] texp  [0:7];
   int         tlive [0:7];                 // 1 for raster low byte and 2 for raster bit 8

   vic_top dut0 (.*);

   bind vic_timing_ctrl vic_properties props0 (
      .clk_dot4x (clk_dot4x), .arst_n (arst_n), .phi (phi), .phi_end (beam.phi_end),
      .dot_stb (beam.dot_stb), .line_start (beam.line_start), .irq (1'b1));
   bind vic_regs vic_properties props0 (
      .clk_dot4x (clk_dot4x), .arst_n (arst_n), .phi (phi_hi), .phi_end (beam.phi_end),
      .dot_stb (beam.dot_stb), .line_start (beam.line_start), .irq (irq));

   initial begin
      clk_dot4x = 1'b0;
      forever #4 clk_dot4x = ~clk_dot4x;    // 8 ns period
   end

   task automatic step();
      @(posedge clk_dot4x);
      #1;                                   // drive and sample just after the edge
      cyc++;
   endtask

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_val(input string name, input int exp, input int act);
      assert (exp == act) else
         fail_now($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act));
   endtask

   function automatic logic probe(input probe_e sel);
      case (sel)
         s_phi:   return phi;
         s_hsync: return hsync;
         s_vsync: return vsync;
         default: return irq;
      endcase
   endfunction

   // n returns the ticks it took
   task automatic wait_level(input probe_e sel, input logic val, input int limit, output int n);
      n = 0;
      while (probe(sel) !== val) begin
         step();
         n++;
         if (n > limit) fail_now($sformatf("timed out waiting for %s to reach %0b",
                                           sel.name(), val));
      end
   endtask

   task automatic cpu_write(input logic [5:0] off, input logic [7:0] data);
      int n;
      wait_level(s_phi, 1'b0, 40, n);
      wait_level(s_phi, 1'b1, 40, n);       // start of phi high
      ce  = 1'b0;
      rw  = 1'b0;
      adl = off;
      dbl = data;
      wait_level(s_phi, 1'b0, 40, n);       // captured on the phi_end tick
      ce = 1'b1;
      rw = 1'b1;
   endtask

   task automatic cpu_read(input logic [5:0] off, output logic [7:0] data);
      int n;
      wait_level(s_phi, 1'b0, 40, n);
      wait_level(s_phi, 1'b1, 40, n);
      ce  = 1'b0;
      rw  = 1'b1;
      adl = off;
      step();                               // dbo follows one tick later
      data = dbo;
      assert (ls245_data_dir === 1'b1) else
         fail_now("ls245_data_dir is low during a read in phi high");
      ce = 1'b1;
   endtask

   task automatic set_row(input int i, input string name, input logic [5:0] off,
                          input logic wr, input logic [7:0] data, input logic [7:0] exp,
                          input int live);
      tname[i] = name;
      toff[i]  = off;
      twr[i]   = wr;
      tdat[i]  = data;
      texp[i]  = exp;
      tlive[i] = live;
   endtask

   // expected pixel outputs from the beam index counted since the vsync rise
   task automatic check_pixel();
      int          idx, ln, dt;
      logic        hs_e, vs_e, act_e, in_win;
      logic [17:0] rgb_e;
      idx    = (cyc - vs_cyc) % frame_t;
      ln     = idx / line_t;
      dt     = (idx % line_t) / dot_ticks;
      hs_e   = dt < hsync_dots;
      vs_e   = ln < vsync_lines;
      act_e  = (dt >= hblank_dots) && (ln >= vblank_lines);
      in_win = (dt >= win_x0) && (dt <= win_x1) && (ln >= win_y0) && (ln <= win_y1);
      rgb_e  = !act_e ? 18'h0 : (in_win ? palette[bg_c] : palette[border_c]);
      assert ({hsync, vsync, active, red, green, blue} === {hs_e, vs_e, act_e, rgb_e}) else
         fail_now($sformatf("Mismatch pixel line %0d dot %0d: expected 0x%0h, actual 0x%0h",
                            ln, dt, {hs_e, vs_e, act_e, rgb_e},
                            {hsync, vsync, active, red, green, blue}));
   endtask

   task automatic scan_to(input int idx_end);
      while (cyc - vs_cyc < idx_end) begin
         step();
         check_pixel();
      end
   endtask

   initial begin
      int         n, n_hi, ln;
      logic [7:0] rd, r1, exp_rd;
      err_cnt  = 0;
      cyc      = 0;
      seed_val = 32'h86f4;
      arst_n   = 1'b0;
      ce       = 1'b1;
      rw       = 1'b1;
      adl      = '0;
      dbl      = '0;
      border_c = 4'($urandom(seed_val));    // seeds the generator once
      bg_c     = 4'((border_c + 1 + $urandom % 15) % 16);   // never equal to border
      repeat (3) step();
      assert ({irq, phi, hsync, vsync, active, ls245_data_dir} === 6'b100000) else
         fail_now("outputs are not at their reset values while arst_n is low");
      arst_n = 1'b1;
      wait_level(s_vsync, 1'b1, 4, n);      // line 0 dot 0 plus output latency
      vs_cyc = cyc;

      wait_level(s_phi, 1'b1, 40, n);
      wait_level(s_phi, 1'b0, 40, n);
      check_val("phi high ticks", 16, n);
      wait_level(s_phi, 1'b1, 40, n);
      check_val("phi low ticks", 16, n);

      set_row(0, "ctrl1", reg_ctrl1, 1'b1, 8'h2a, 8'h2a, 2);
      set_row(1, "raster", reg_raster, 1'b1, 8'd100, 8'h00, 1);   // compare line 100
      set_row(2, "border", reg_border, 1'b1, {4'($urandom), border_c}, {4'hf, border_c}, 0);
      set_row(3, "bg", reg_bg, 1'b1, {4'($urandom), bg_c}, {4'hf, bg_c}, 0);
      exp_rd = 8'($urandom) & 8'hfe;        // raster enable stays off for now
      set_row(4, "irq_en", reg_irq_en, 1'b1, exp_rd, exp_rd, 0);
      set_row(5, "unused 0x3f", 6'h3f, 1'b1, 8'h55, 8'hff, 0);
      set_row(6, "unused 0x00", 6'h00, 1'b0, 8'h00, 8'hff, 0);
      set_row(7, "bg reread", reg_bg, 1'b0, 8'h00, {4'hf, bg_c}, 0);
      for (int i = 0; i < 8; i++) begin
         if (twr[i]) cpu_write(toff[i], tdat[i]);
         cpu_read(toff[i], rd);
         ln     = ((cyc - vs_cyc) % frame_t) / line_t;
         exp_rd = texp[i];
         if (tlive[i] == 1) exp_rd = exp_rd | ln[7:0];
         if (tlive[i] == 2) exp_rd[7] = ln[8];
         check_val(tname[i], exp_rd, rd);
      end

      cpu_write(reg_irq_stat, 8'h01);       // drop the line 0 match left from reset
      cpu_write(reg_irq_en, 8'h01);
      check_val("irq after enable", 1, irq);

      wait_level(s_hsync, 1'b0, line_t, n);
      wait_level(s_hsync, 1'b1, line_t, n);
      wait_level(s_hsync, 1'b0, line_t, n_hi);
      check_val("hsync high ticks", 160, n_hi);
      wait_level(s_hsync, 1'b1, line_t, n);
      check_val("hsync period", 2080, n_hi + n);

      // raster irq at line 100
      scan_to(100 * line_t - 1);
      check_val("irq before line 100", 1, irq);
      scan_to(100 * line_t);
      check_val("irq at line 100 dot 0", 0, irq);
      cpu_read(reg_irq_stat, rd);
      check_val("irq_stat after match", 8'h81, rd);
      cpu_write(reg_irq_stat, 8'h01);
      check_val("irq after clear", 1, irq);
      cpu_write(reg_irq_en, 8'h00);
      cpu_write(reg_raster, 8'd110);
      scan_to(110 * line_t + 8);
      check_val("irq with enable clear", 1, irq);
      cpu_read(reg_irq_stat, rd);
      check_val("irq_stat without enable", 8'h01, rd);

      // live raster reads 37 lines apart
      cpu_read(reg_raster, r1);
      ln = ((cyc - vs_cyc) % frame_t) / line_t;
      check_val("raster first read", ln & 8'hff, r1);
      scan_to((ln + 37) * line_t + 100);    // early in the line 37 lines on
      cpu_read(reg_raster, rd);
      check_val("raster 37 lines later", (ln + 37) & 8'hff, rd);

      scan_to(frame_t - 1);
      wait_level(s_vsync, 1'b1, 4, n);
      check_val("frame period", frame_t, cyc - vs_cyc);
      wait_level(s_vsync, 1'b0, frame_t, n);
      check_val("vsync high ticks", 3 * line_t, n);

      err_cnt = dut0.timing0.props0.fail_cnt + dut0.regs0.props0.fail_cnt;
      if (err_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: list.f
design/vic_pkg.sv
design/vic_beam_if.sv
design/vic_timing_ctrl.sv
design/vic_regs.sv
design/vic_pixel.sv
design/vic_top.sv
verif/vic_properties.sv
verif/vic_tb.sv

// File: Bender.yml
package:
  name: vic

sources:
  - design/vic_pkg.sv
  - design/vic_beam_if.sv
  - design/vic_timing_ctrl.sv
  - design/vic_regs.sv
  - design/vic_pixel.sv
  - design/vic_top.sv
  - target: simulation
    files:
      - verif/vic_properties.sv
      - verif/vic_tb.sv
